//--- verilog/isaPkg.sv
package isaPkg;

	//////////////////////////////
	// field types
	//////////////////////////////

	typedef logic [31:0] instrWord_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  regAddr_t;

	//////////////////////////////
	// major opcodes
	//////////////////////////////

	localparam opcode_t opSpecial = 6'b000000;
	localparam opcode_t opRegimm  = 6'b000001;
	localparam opcode_t opJ       = 6'b000010;
	localparam opcode_t opJal     = 6'b000011;
	localparam opcode_t opBeq     = 6'b000100;
	localparam opcode_t opBne     = 6'b000101;
	localparam opcode_t opBlez    = 6'b000110;
	localparam opcode_t opBgtz    = 6'b000111;
	localparam opcode_t opAddi    = 6'b001000;
	localparam opcode_t opAddiu   = 6'b001001;
	localparam opcode_t opSlti    = 6'b001010;
	localparam opcode_t opSltiu   = 6'b001011;
	localparam opcode_t opAndi    = 6'b001100;
	localparam opcode_t opOri     = 6'b001101;
	localparam opcode_t opXori    = 6'b001110;
	localparam opcode_t opLui     = 6'b001111;
	// the likely forms differ from the plain branches only in bit 4.
	localparam opcode_t opBeql    = 6'b010100;
	localparam opcode_t opBnel    = 6'b010101;
	localparam opcode_t opBlezl   = 6'b010110;
	localparam opcode_t opBgtzl   = 6'b010111;
	localparam opcode_t opLb      = 6'b100000;
	localparam opcode_t opLh      = 6'b100001;
	localparam opcode_t opLw      = 6'b100011;
	localparam opcode_t opLbu     = 6'b100100;
	localparam opcode_t opLhu     = 6'b100101;
	localparam opcode_t opSb      = 6'b101000;
	localparam opcode_t opSh      = 6'b101001;
	localparam opcode_t opSw      = 6'b101011;

	//////////////////////////////
	// SPECIAL funct codes
	//////////////////////////////

	localparam funct_t fnSll     = 6'b000000;
	localparam funct_t fnSrl     = 6'b000010;
	localparam funct_t fnSra     = 6'b000011;
	localparam funct_t fnSllv    = 6'b000100;
	localparam funct_t fnSrlv    = 6'b000110;
	localparam funct_t fnSrav    = 6'b000111;
	localparam funct_t fnJr      = 6'b001000;
	localparam funct_t fnJalr    = 6'b001001;
	localparam funct_t fnSyscall = 6'b001100;
	localparam funct_t fnBreak   = 6'b001101;
	localparam funct_t fnAdd     = 6'b100000;
	localparam funct_t fnAddu    = 6'b100001;
	localparam funct_t fnSub     = 6'b100010;
	localparam funct_t fnSubu    = 6'b100011;
	localparam funct_t fnAnd     = 6'b100100;
	localparam funct_t fnOr      = 6'b100101;
	localparam funct_t fnXor     = 6'b100110;
	localparam funct_t fnNor     = 6'b100111;
	localparam funct_t fnSlt     = 6'b101010;
	localparam funct_t fnSltu    = 6'b101011;

	// REGIMM codes live in the rt field.
	// bit 0 picks gez over ltz, bit 1 marks likely and bit 4 marks link.
	localparam regAddr_t rtBltz    = 5'b00000;
	localparam regAddr_t rtBgez    = 5'b00001;
	localparam regAddr_t rtBltzl   = 5'b00010;
	localparam regAddr_t rtBgezl   = 5'b00011;
	localparam regAddr_t rtBltzal  = 5'b10000;
	localparam regAddr_t rtBgezal  = 5'b10001;
	localparam regAddr_t rtBltzall = 5'b10010;
	localparam regAddr_t rtBgezall = 5'b10011;

endpackage

//--- verilog/ctrlPkg.sv
package ctrlPkg;

	//////////////////////////////
	// datapath encodings
	//////////////////////////////

	typedef enum logic [3:0] {
		aluAdd,
		aluAddu,
		aluSub,
		aluSubu,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu,
		aluNone
	} aluOp_t;

	typedef enum logic [1:0] {extZero, extSign, extUpper} extOp_t;

	typedef enum logic [1:0] {destRt, destRd, destLink} destSel_t;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink, wbUpper} wbSel_t;

	typedef enum logic [2:0] {
		memByte,
		memByteUnsigned,
		memHalf,
		memHalfUnsigned,
		memWord
	} memSize_t;

	//////////////////////////////
	// control flow
	//////////////////////////////

	typedef enum logic [1:0] {
		npcSequential,
		npcBranch,
		npcJumpImmediate,
		npcJumpRegister
	} npcOp_t;

	typedef enum logic [3:0] {
		brNone,
		brEq,
		brNe,
		brLez,
		brGtz,
		brLtz,
		brGez,
		brJump,
		brJumpReg
	} branchKind_t;

	// sign of register rs, as reported by the comparator.
	typedef enum logic [1:0] {signZero, signPositive, signNegative} cmpSign_t;

	typedef logic [4:0] excCode_t;

	localparam excCode_t excSys = 5'd8;
	localparam excCode_t excBp  = 5'd9;
	localparam excCode_t excRi  = 5'd10;

	//////////////////////////////
	// structs between stages
	//////////////////////////////

	typedef struct packed {
		logic     notEqual;
		cmpSign_t rsSign;
	} cmpFlags_t;

	typedef struct packed {
		logic     valid;
		excCode_t code;
	} fetchFault_t;

	// bSelImm selects the extended immediate as ALU operand B.
	typedef struct packed {
		aluOp_t   aluOp;
		extOp_t   extOp;
		logic     bSelImm;
		logic     regWrite;
		destSel_t destSel;
		wbSel_t   wbSel;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
	} datapathCtrl_t;

	localparam datapathCtrl_t dpIdle = '{
		aluOp: aluNone, extOp: extZero, bSelImm: 1'b0, regWrite: 1'b0,
		destSel: destRt, wbSel: wbAlu, memRead: 1'b0, memWrite: 1'b0,
		memSize: memWord
	};

	typedef struct packed {
		datapathCtrl_t dp;
		branchKind_t   branchKind;
		logic          likely;
		logic          reservedOp;
		logic          breakOp;
		logic          syscallOp;
		cmpFlags_t     cmpFlags;
		fetchFault_t   fetchFault;
	} decodedOp_t;

	typedef struct packed {
		decodedOp_t dec;
		npcOp_t     npcOp;
		logic       jump;
		logic       likelyFlush;
	} resolvedOp_t;

	typedef struct packed {
		datapathCtrl_t dp;
		npcOp_t        npcOp;
		logic          jump;
		logic          likelyFlush;
		logic          exception;
		excCode_t      excCode;
		logic          isBD;
	} ctrlWord_t;

endpackage

//--- verilog/decodeStage.sv
`timescale 1ns/100ps

module decodeStage #(
	parameter bit SupportLikely = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inValid,
	input  isaPkg::instrWord_t   instr,
	input  ctrlPkg::cmpFlags_t   cmpFlags,
	input  ctrlPkg::fetchFault_t fetchFault,
	output logic                 decValid,
	output ctrlPkg::decodedOp_t  dec
);
	import isaPkg::*;
	import ctrlPkg::*;

	opcode_t    op;
	regAddr_t   rt;
	funct_t     fn;
	decodedOp_t decNext;

	// register and immediate ALU forms.
	// immediate forms write rt, register forms write rd.
	function automatic datapathCtrl_t aluCtrl(aluOp_t alu, extOp_t ext, logic useImm);
		datapathCtrl_t c;
		c = dpIdle;
		c.aluOp = alu;
		c.extOp = ext;
		c.bSelImm = useImm;
		c.regWrite = 1'b1;
		c.destSel = useImm ? destRt : destRd;
		return c;
	endfunction

	// address is always base plus sign-extended offset.
	function automatic datapathCtrl_t memCtrl(logic load, memSize_t size);
		datapathCtrl_t c;
		c = dpIdle;
		c.aluOp = aluAdd;
		c.extOp = extSign;
		c.bSelImm = 1'b1;
		c.memRead = load;
		c.memWrite = !load;
		c.memSize = size;
		c.regWrite = load;
		c.wbSel = load ? wbMem : wbAlu;
		return c;
	endfunction

	function automatic datapathCtrl_t linkCtrl(destSel_t dest);
		datapathCtrl_t c;
		c = dpIdle;
		c.regWrite = 1'b1;
		c.destSel = dest;
		c.wbSel = wbLink;
		return c;
	endfunction

	assign op = instr[31:26];
	assign rt = instr[20:16];
	assign fn = instr[5:0];

	//////////////////////////////
	// instruction classification
	//////////////////////////////

	// shifts by shamt and by rs share an ALU op.
	// the datapath tells them apart by funct bit 2.
	always_comb begin
		decNext = '{dp: dpIdle, branchKind: brNone, likely: 1'b0, reservedOp: 1'b0,
			breakOp: 1'b0, syscallOp: 1'b0, cmpFlags: cmpFlags, fetchFault: fetchFault};
		case (op)
			opSpecial: begin
				case (fn)
					fnAdd:         decNext.dp = aluCtrl(aluAdd, extZero, 1'b0);
					fnAddu:        decNext.dp = aluCtrl(aluAddu, extZero, 1'b0);
					fnSub:         decNext.dp = aluCtrl(aluSub, extZero, 1'b0);
					fnSubu:        decNext.dp = aluCtrl(aluSubu, extZero, 1'b0);
					fnAnd:         decNext.dp = aluCtrl(aluAnd, extZero, 1'b0);
					fnOr:          decNext.dp = aluCtrl(aluOr, extZero, 1'b0);
					fnXor:         decNext.dp = aluCtrl(aluXor, extZero, 1'b0);
					fnNor:         decNext.dp = aluCtrl(aluNor, extZero, 1'b0);
					fnSlt:         decNext.dp = aluCtrl(aluSlt, extZero, 1'b0);
					fnSltu:        decNext.dp = aluCtrl(aluSltu, extZero, 1'b0);
					fnSll, fnSllv: decNext.dp = aluCtrl(aluSll, extZero, 1'b0);
					fnSrl, fnSrlv: decNext.dp = aluCtrl(aluSrl, extZero, 1'b0);
					fnSra, fnSrav: decNext.dp = aluCtrl(aluSra, extZero, 1'b0);
					fnJr:          decNext.branchKind = brJumpReg;
					fnJalr: begin
						decNext.branchKind = brJumpReg;
						decNext.dp = linkCtrl(destRd);
					end
					fnBreak:       decNext.breakOp = 1'b1;
					fnSyscall:     decNext.syscallOp = 1'b1;
					default:       decNext.reservedOp = 1'b1;
				endcase
			end
			opRegimm: begin
				case (rt)
					rtBltz, rtBgez, rtBltzl, rtBgezl,
					rtBltzal, rtBgezal, rtBltzall, rtBgezall: begin
						decNext.branchKind = rt[0] ? brGez : brLtz;
						decNext.likely = rt[1];
						if (rt[4])
							decNext.dp = linkCtrl(destLink);
					end
					default: decNext.reservedOp = 1'b1;
				endcase
			end
			opJ:
				decNext.branchKind = brJump;
			opJal: begin
				decNext.branchKind = brJump;
				decNext.dp = linkCtrl(destLink);
			end
			// op bit 4 is the likely bit for the four compare branches.
			opBeq, opBeql: begin
				decNext.branchKind = brEq;
				decNext.likely = op[4];
			end
			opBne, opBnel: begin
				decNext.branchKind = brNe;
				decNext.likely = op[4];
			end
			opBlez, opBlezl: begin
				decNext.branchKind = brLez;
				decNext.likely = op[4];
			end
			opBgtz, opBgtzl: begin
				decNext.branchKind = brGtz;
				decNext.likely = op[4];
			end
			opAddi:  decNext.dp = aluCtrl(aluAdd, extSign, 1'b1);
			opAddiu: decNext.dp = aluCtrl(aluAddu, extSign, 1'b1);
			opSlti:  decNext.dp = aluCtrl(aluSlt, extSign, 1'b1);
			opSltiu: decNext.dp = aluCtrl(aluSltu, extSign, 1'b1);
			opAndi:  decNext.dp = aluCtrl(aluAnd, extZero, 1'b1);
			opOri:   decNext.dp = aluCtrl(aluOr, extZero, 1'b1);
			opXori:  decNext.dp = aluCtrl(aluXor, extZero, 1'b1);
			opLui: begin
				decNext.dp = aluCtrl(aluNone, extUpper, 1'b1);
				decNext.dp.wbSel = wbUpper;
			end
			opLb:    decNext.dp = memCtrl(1'b1, memByte);
			opLbu:   decNext.dp = memCtrl(1'b1, memByteUnsigned);
			opLh:    decNext.dp = memCtrl(1'b1, memHalf);
			opLhu:   decNext.dp = memCtrl(1'b1, memHalfUnsigned);
			opLw:    decNext.dp = memCtrl(1'b1, memWord);
			opSb:    decNext.dp = memCtrl(1'b0, memByte);
			opSh:    decNext.dp = memCtrl(1'b0, memHalf);
			opSw:    decNext.dp = memCtrl(1'b0, memWord);
			default: decNext.reservedOp = 1'b1;
		endcase

		// without likely support the likely encodings become reserved.
		if (decNext.likely && !SupportLikely) begin
			decNext.dp = dpIdle;
			decNext.branchKind = brNone;
			decNext.likely = 1'b0;
			decNext.reservedOp = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst)
			decValid <= 1'b0;
		else
			decValid <= inValid;
	end

	always_ff @(posedge clk) begin
		dec <= decNext;
	end

endmodule

//--- verilog/branchStage.sv
`timescale 1ns/100ps

module branchStage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 decValid,
	input  ctrlPkg::decodedOp_t  dec,
	output logic                 resValid,
	output ctrlPkg::resolvedOp_t res
);
	import ctrlPkg::*;

	logic   taken;
	npcOp_t npcNext;

	//////////////////////////////
	// branch condition
	//////////////////////////////

	// jumps and non-branches never count as taken here.
	always_comb begin
		case (dec.branchKind)
			brEq:    taken = !dec.cmpFlags.notEqual;
			brNe:    taken = dec.cmpFlags.notEqual;
			brLez:   taken = dec.cmpFlags.rsSign != signPositive;
			brGtz:   taken = dec.cmpFlags.rsSign == signPositive;
			brLtz:   taken = dec.cmpFlags.rsSign == signNegative;
			brGez:   taken = dec.cmpFlags.rsSign != signNegative;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.branchKind)
			brJump:    npcNext = npcJumpImmediate;
			brJumpReg: npcNext = npcJumpRegister;
			default:   npcNext = taken ? npcBranch : npcSequential;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst)
			resValid <= 1'b0;
		else
			resValid <= decValid;
	end

	// a likely branch that falls through kills its delay slot.
	always_ff @(posedge clk) begin
		res <= '{
			dec: dec,
			npcOp: npcNext,
			jump: npcNext != npcSequential,
			likelyFlush: dec.likely && !taken
		};
	end

endmodule

//--- verilog/exceptionStage.sv
`timescale 1ns/100ps

module exceptionStage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 resValid,
	input  ctrlPkg::resolvedOp_t res,
	output logic                 outValid,
	output ctrlPkg::ctrlWord_t   ctrl
);
	import ctrlPkg::*;

	logic          excHit;
	excCode_t      excSel;
	logic          prevBranch;
	logic          excQ;
	logic          jumpQ;
	logic          flushQ;
	logic          bdQ;
	datapathCtrl_t dpQ;
	npcOp_t        npcQ;
	excCode_t      codeQ;

	// fetch faults happened first, so they win over anything decoded.
	always_comb begin
		excHit = 1'b1;
		if (res.dec.fetchFault.valid)
			excSel = res.dec.fetchFault.code;
		else if (res.dec.reservedOp)
			excSel = excRi;
		else if (res.dec.breakOp)
			excSel = excBp;
		else if (res.dec.syscallOp)
			excSel = excSys;
		else begin
			excHit = 1'b0;
			excSel = '0;
		end
	end

	//////////////////////////////
	// flags and delay slot
	//////////////////////////////

	// bubbles raise no flags and leave the branch history alone.
	always_ff @(posedge clk) begin
		if (!rst) begin
			outValid <= 1'b0;
			prevBranch <= 1'b0;
			excQ <= 1'b0;
			jumpQ <= 1'b0;
			flushQ <= 1'b0;
		end else begin
			outValid <= resValid;
			excQ <= resValid && excHit;
			jumpQ <= resValid && res.jump;
			flushQ <= resValid && res.likelyFlush;
			if (resValid)
				prevBranch <= res.dec.branchKind != brNone;
		end
	end

	always_ff @(posedge clk) begin
		dpQ <= res.dec.dp;
		npcQ <= res.npcOp;
		codeQ <= excSel;
		bdQ <= prevBranch;
	end

	assign ctrl = '{dp: dpQ, npcOp: npcQ, jump: jumpQ, likelyFlush: flushQ,
		exception: excQ, excCode: codeQ, isBD: bdQ};

endmodule

//--- verilog/instrDecodePipe.sv
`timescale 1ns/100ps

module instrDecodePipe #(
	parameter bit SupportLikely = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inValid,
	input  isaPkg::instrWord_t   instr,
	input  ctrlPkg::cmpFlags_t   cmpFlags,
	input  ctrlPkg::fetchFault_t fetchFault,
	output logic                 outValid,
	output ctrlPkg::ctrlWord_t   ctrl
);
	import ctrlPkg::*;

	// three registered stages, so an accepted word comes out three cycles later.
	logic        decValid;
	decodedOp_t  dec;
	logic        resValid;
	resolvedOp_t res;

	decodeStage #(
		.SupportLikely(SupportLikely)
	) decodeStage_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instr(instr),
		.cmpFlags(cmpFlags),
		.fetchFault(fetchFault),
		.decValid(decValid),
		.dec(dec)
	);

	branchStage branchStage_i (
		.clk(clk),
		.rst(rst),
		.decValid(decValid),
		.dec(dec),
		.resValid(resValid),
		.res(res)
	);

	exceptionStage exceptionStage_i (
		.clk(clk),
		.rst(rst),
		.resValid(resValid),
		.res(res),
		.outValid(outValid),
		.ctrl(ctrl)
	);

endmodule

//--- sim/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected control words, written from the instruction tables of the kept set.
// the including module imports isaPkg and ctrlPkg.

function automatic logic isKnown(instrWord_t w);
	opcode_t op;
	op = w[31:26];
	if (op == opSpecial)
		return w[5:0] inside {fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
			fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnJalr,
			fnBreak, fnSyscall};
	if (op == opRegimm)
		return w[20:16] inside {rtBltz, rtBgez, rtBltzl, rtBgezl, rtBltzal, rtBgezal,
			rtBltzall, rtBgezall};
	return op inside {opJ, opJal, opBeq, opBne, opBlez, opBgtz, opBeql, opBnel, opBlezl,
		opBgtzl, opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opLb,
		opLbu, opLh, opLhu, opLw, opSb, opSh, opSw};
endfunction

function automatic branchKind_t branchKindOf(instrWord_t w);
	opcode_t op;
	regAddr_t rt;
	op = w[31:26];
	rt = w[20:16];
	if (!isKnown(w))
		return brNone;
	case (op)
		opSpecial:       return (w[5:0] inside {fnJr, fnJalr}) ? brJumpReg : brNone;
		opRegimm:        return (rt inside {rtBltz, rtBltzl, rtBltzal, rtBltzall}) ? brLtz : brGez;
		opJ, opJal:      return brJump;
		opBeq, opBeql:   return brEq;
		opBne, opBnel:   return brNe;
		opBlez, opBlezl: return brLez;
		opBgtz, opBgtzl: return brGtz;
		default:         return brNone;
	endcase
endfunction

function automatic logic isLikely(instrWord_t w);
	opcode_t op;
	op = w[31:26];
	return op inside {opBeql, opBnel, opBlezl, opBgtzl} ||
		(op == opRegimm && w[20:16] inside {rtBltzl, rtBgezl, rtBltzall, rtBgezall});
endfunction

function automatic logic isTaken(branchKind_t kind, cmpFlags_t flags);
	case (kind)
		brEq:    return !flags.notEqual;
		brNe:    return flags.notEqual;
		brLez:   return flags.rsSign != signPositive;
		brGtz:   return flags.rsSign == signPositive;
		brLtz:   return flags.rsSign == signNegative;
		brGez:   return flags.rsSign != signNegative;
		default: return 1'b0;
	endcase
endfunction

function automatic datapathCtrl_t datapathFor(instrWord_t w);
	datapathCtrl_t d;
	opcode_t op;
	logic load;
	op = w[31:26];
	load = op inside {opLb, opLbu, opLh, opLhu, opLw};
	d = '{aluNone, extZero, 1'b0, 1'b0, destRt, wbAlu, 1'b0, 1'b0, memWord};
	if (!isKnown(w))
		return d;
	if (op == opSpecial) begin
		d.regWrite = 1'b1;
		d.destSel = destRd;
		case (w[5:0])
			fnAdd:         d.aluOp = aluAdd;
			fnAddu:        d.aluOp = aluAddu;
			fnSub:         d.aluOp = aluSub;
			fnSubu:        d.aluOp = aluSubu;
			fnAnd:         d.aluOp = aluAnd;
			fnOr:          d.aluOp = aluOr;
			fnXor:         d.aluOp = aluXor;
			fnNor:         d.aluOp = aluNor;
			fnSlt:         d.aluOp = aluSlt;
			fnSltu:        d.aluOp = aluSltu;
			fnSll, fnSllv: d.aluOp = aluSll;
			fnSrl, fnSrlv: d.aluOp = aluSrl;
			fnSra, fnSrav: d.aluOp = aluSra;
			fnJalr:        d.wbSel = wbLink;
			default: begin
				d.regWrite = 1'b0;
				d.destSel = destRt;
			end
		endcase
	end else if (op inside {opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui}) begin
		d.bSelImm = 1'b1;
		d.regWrite = 1'b1;
		d.extOp = (op inside {opAndi, opOri, opXori}) ? extZero : extSign;
		case (op)
			opAddi:  d.aluOp = aluAdd;
			opAddiu: d.aluOp = aluAddu;
			opSlti:  d.aluOp = aluSlt;
			opSltiu: d.aluOp = aluSltu;
			opAndi:  d.aluOp = aluAnd;
			opOri:   d.aluOp = aluOr;
			opXori:  d.aluOp = aluXor;
			default: begin
				d.extOp = extUpper;
				d.wbSel = wbUpper;
			end
		endcase
	end else if (load || op inside {opSb, opSh, opSw}) begin
		d.aluOp = aluAdd;
		d.extOp = extSign;
		d.bSelImm = 1'b1;
		d.memRead = load;
		d.memWrite = !load;
		d.regWrite = load;
		if (load)
			d.wbSel = wbMem;
		case (op)
			opLb, opSb: d.memSize = memByte;
			opLbu:      d.memSize = memByteUnsigned;
			opLh, opSh: d.memSize = memHalf;
			opLhu:      d.memSize = memHalfUnsigned;
			default:    d.memSize = memWord;
		endcase
	end else if (op == opJal ||
			(op == opRegimm && w[20:16] inside {rtBltzal, rtBgezal, rtBltzall, rtBgezall})) begin
		d.regWrite = 1'b1;
		d.destSel = destLink;
		d.wbSel = wbLink;
	end
	return d;
endfunction

// a fetch fault comes first, then reserved, break and syscall.
function automatic logic exceptionFor(instrWord_t w, fetchFault_t fault,
		output excCode_t code);
	logic special;
	special = w[31:26] == opSpecial;
	code = '0;
	if (fault.valid)
		code = fault.code;
	else if (!isKnown(w))
		code = excRi;
	else if (special && w[5:0] == fnBreak)
		code = excBp;
	else if (special && w[5:0] == fnSyscall)
		code = excSys;
	else
		return 1'b0;
	return 1'b1;
endfunction

function automatic ctrlWord_t expectedCtrl(instrWord_t w, cmpFlags_t flags,
		fetchFault_t fault, logic afterBranch);
	ctrlWord_t c;
	branchKind_t kind;
	logic taken;
	excCode_t code;
	kind = branchKindOf(w);
	taken = isTaken(kind, flags);
	c.dp = datapathFor(w);
	case (kind)
		brJump:    c.npcOp = npcJumpImmediate;
		brJumpReg: c.npcOp = npcJumpRegister;
		default:   c.npcOp = taken ? npcBranch : npcSequential;
	endcase
	c.jump = c.npcOp != npcSequential;
	c.likelyFlush = isLikely(w) && !taken;
	c.exception = exceptionFor(w, fault, code);
	c.excCode = code;
	c.isBD = afterBranch;
	return c;
endfunction

`endif

//--- sim/tbDecodePipe.sv
`timescale 1ns/100ps

module tbDecodePipe;
	import isaPkg::*;
	import ctrlPkg::*;

	`include "decodeModel.svh"

	localparam int ClkPeriod = 40;
	localparam int ResetCycles = 4;
	localparam int RandomCount = 300;

	localparam opcode_t KeptOps[28] = '{opSpecial, opRegimm, opJ, opJal, opBeq, opBne,
		opBlez, opBgtz, opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui,
		opBeql, opBnel, opBlezl, opBgtzl, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
	localparam funct_t KeptFns[20] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor,
		fnNor, fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnJalr,
		fnBreak, fnSyscall};
	localparam regAddr_t RegimmRts[8] = '{rtBltz, rtBgez, rtBltzl, rtBgezl, rtBltzal,
		rtBgezal, rtBltzall, rtBgezall};
	localparam opcode_t BranchOps[8] = '{opBeq, opBne, opBlez, opBgtz, opBeql, opBnel,
		opBlezl, opBgtzl};

	logic        clk;
	logic        rst;
	logic        inValid;
	instrWord_t  instr;
	cmpFlags_t   cmpFlags;
	fetchFault_t fetchFault;
	logic        outValid;
	ctrlWord_t   ctrl;

	// stimulus list, filled in before the run starts.
	string       stimName[$];
	instrWord_t  stimInstr[$];
	cmpFlags_t   stimFlags[$];
	fetchFault_t stimFault[$];
	logic        stimValid[$];
	logic        stimReady;

	// expected words in issue order, each with the cycle it is due in.
	string     expName[$];
	ctrlWord_t expWord[$];
	int        expDue[$];

	int     cycle;
	int     errors;
	int     checks;
	integer seed;
	logic   lastBranch;

	instrDecodePipe #(
		.SupportLikely(1'b1)
	) instrDecodePipe_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.instr(instr),
		.cmpFlags(cmpFlags),
		.fetchFault(fetchFault),
		.outValid(outValid),
		.ctrl(ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = !clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic addStim(string name, instrWord_t w, cmpFlags_t f, fetchFault_t ff,
			logic v);
		stimName.push_back(name);
		stimInstr.push_back(w);
		stimFlags.push_back(f);
		stimFault.push_back(ff);
		stimValid.push_back(v);
	endtask

	//////////////////////////////
	// stimulus lists
	//////////////////////////////

	task automatic buildDirected();
		cmpFlags_t f;
		fetchFault_t none;
		int s;
		int e;
		none = '{1'b0, 5'd0};
		f = '{1'b0, signZero};
		foreach (KeptFns[i])
			addStim($sformatf("funct %h", KeptFns[i]), {opSpecial, 5'd3, 5'd4, 5'd5, 5'd2,
				KeptFns[i]}, f, none, 1'b1);
		addStim("bubble", '0, f, none, 1'b0);
		foreach (KeptOps[i])
			addStim($sformatf("opcode %h", KeptOps[i]), {KeptOps[i], 5'd6, 5'd7, 16'h8001},
				f, none, 1'b1);
		// every branch under each sign of rs and both equality results.
		for (s = 0; s < 3; s++) begin
			for (e = 0; e < 2; e++) begin
				f = '{e[0], cmpSign_t'(s)};
				foreach (BranchOps[i])
					addStim($sformatf("branch %h s%0d e%0d", BranchOps[i], s, e),
						{BranchOps[i], 5'd1, 5'd2, 16'hfffc}, f, none, 1'b1);
				addStim("bubble", '0, f, none, 1'b0);
				foreach (RegimmRts[i])
					addStim($sformatf("regimm %h s%0d e%0d", RegimmRts[i], s, e),
						{opRegimm, 5'd1, RegimmRts[i], 16'h0010}, f, none, 1'b1);
			end
		end
		f = '{1'b1, signNegative};
		addStim("fault over reserved", 32'hfc000000, f, '{1'b1, 5'd4}, 1'b1);
		addStim("fault over break", {opSpecial, 20'd0, fnBreak}, f, '{1'b1, 5'd6}, 1'b1);
		addStim("fault over syscall", {opSpecial, 20'd0, fnSyscall}, f, '{1'b1, 5'd5}, 1'b1);
		addStim("fault on branch", {opBeq, 5'd1, 5'd2, 16'd4}, f, '{1'b1, 5'd2}, 1'b1);
		addStim("reserved opcode", 32'hfc000000, f, none, 1'b1);
		addStim("reserved funct", {opSpecial, 20'd0, 6'b111111}, f, none, 1'b1);
		addStim("reserved regimm", {opRegimm, 5'd0, 5'b00100, 16'd0}, f, none, 1'b1);
		addStim("break", {opSpecial, 20'd0, fnBreak}, f, none, 1'b1);
		addStim("syscall", {opSpecial, 20'd0, fnSyscall}, f, none, 1'b1);
	endtask

	// mostly kept encodings with random register fields and the odd fault or bubble.
	task automatic buildRandom();
		instrWord_t w;
		cmpFlags_t f;
		fetchFault_t ff;
		int pick;
		int r;
		for (int n = 0; n < RandomCount; n++) begin
			w = $random(seed);
			pick = $unsigned($random(seed)) % 10;
			if (pick < 9)
				w[31:26] = KeptOps[$unsigned($random(seed)) % 28];
			if (pick < 8 && w[31:26] == opSpecial)
				w[5:0] = KeptFns[$unsigned($random(seed)) % 20];
			if (pick < 8 && w[31:26] == opRegimm)
				w[20:16] = RegimmRts[$unsigned($random(seed)) % 8];
			f.notEqual = ($unsigned($random(seed)) % 2) != 0;
			f.rsSign = cmpSign_t'($unsigned($random(seed)) % 3);
			r = $random(seed);
			ff.valid = ($unsigned($random(seed)) % 16) == 0;
			ff.code = r[4:0];
			addStim($sformatf("random %0d", n), w, f, ff, ($unsigned($random(seed)) % 8) != 0);
		end
	endtask

	task automatic driveItem(int i);
		inValid = stimValid[i];
		instr = stimInstr[i];
		cmpFlags = stimFlags[i];
		fetchFault = stimFault[i];
		if (stimValid[i]) begin
			expName.push_back(stimName[i]);
			expWord.push_back(expectedCtrl(stimInstr[i], stimFlags[i], stimFault[i],
				lastBranch));
			expDue.push_back(cycle + 3);
			lastBranch = branchKindOf(stimInstr[i]) != brNone;
		end
	endtask

	//////////////////////////////
	// checking
	//////////////////////////////

	// outputs settle at the rising edge, so the falling edge sees them stable.
	// the clock's first step to zero is no real edge and is skipped.
	always @(negedge clk) begin
		logic due;
		if (cycle > 0) begin
			due = expDue.size() != 0 && expDue[0] == cycle;
			latency_check: assert (outValid === due) else begin
				errors++;
				$display("[ERROR] latency: expected outValid %b, actual %b in cycle %0d",
					due, outValid, cycle);
			end
			if (due) begin
				if (outValid === 1'b1) begin
					checks++;
					word_check: assert (ctrl === expWord[0]) else begin
						errors++;
						$display("[ERROR] %s: expected %h, actual %h", expName[0],
							expWord[0], ctrl);
					end
				end
				void'(expName.pop_front());
				void'(expWord.pop_front());
				void'(expDue.pop_front());
			end
		end
	end

	initial begin
		wait (stimReady);
		#((ResetCycles + stimInstr.size() + 20) * ClkPeriod);
		$display("the run timed out before every expected control word came out");
		$display("Checks failed");
		$finish;
	end

	initial begin
		stimReady = 1'b0;
		seed = 93798;
		cycle = 0;
		errors = 0;
		checks = 0;
		lastBranch = 1'b0;
		rst = 1'b0;
		inValid = 1'b0;
		instr = '0;
		cmpFlags = '{1'b0, signZero};
		fetchFault = '{1'b0, 5'd0};
		buildDirected();
		buildRandom();
		stimReady = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		#2;
		rst = 1'b1;
		reset_check: assert (outValid === 1'b0 && ctrl.exception === 1'b0 &&
				ctrl.jump === 1'b0 && ctrl.likelyFlush === 1'b0) else begin
			errors++;
			$display("[ERROR] reset: expected 0000, actual %b%b%b%b", outValid,
				ctrl.exception, ctrl.jump, ctrl.likelyFlush);
		end
		foreach (stimInstr[i]) begin
			driveItem(i);
			@(posedge clk);
			#2;
		end
		inValid = 1'b0;
		while (expDue.size() != 0)
			@(negedge clk);
		$display("%0d words checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+sim
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/decodeStage.sv
verilog/branchStage.sv
verilog/exceptionStage.sv
verilog/instrDecodePipe.sv
sim/tbDecodePipe.sv
